// File: design/uart_cfg_pkg.sv
/*
  serial line timing constants and the bit-time counter type
*/
package uart_cfg_pkg;

  // clock cycles that make up one serial bit
  localparam int clks_per_bit = 8;

  // the edge detect in idle already used one clock of the start bit,
  // so the count to mid start bit is one short of half a bit
  localparam int half_bit = clks_per_bit / 2 - 1;

  // counter width, enough to count down from clks_per_bit - 1
  localparam int bit_cnt_w = $clog2(clks_per_bit);

  // counts clocks inside one bit time
  typedef logic [bit_cnt_w-1:0] bit_cnt_t;

endpackage

// File: design/uart_data_pkg.sv
/*
  data word and bit index types, plus state encodings for the receiver,
  the transmitter and the host channel controllers
*/
package uart_data_pkg;

  // one data byte of a frame
  typedef logic [7:0] byte_t;

  // position of a data bit inside the frame, LSB first
  typedef logic [2:0] bit_idx_t;

  // receiver FSM
  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop,
    rx_wait_release
  } rx_state_t;

  // transmitter FSM
  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop,
    tx_wait_release
  } tx_state_t;

  // one per host channel, walks through the four-phase handshake
  typedef enum logic [1:0] {
    ctrl_idle,
    ctrl_busy,
    ctrl_ack,
    ctrl_release
  } ctrl_state_t;

endpackage

// File: design/uart_rx.sv
/*
  UART receiver for 8N1 frames that samples each bit in its middle while rx_go
  is high and hands the byte and a framing flag back over the rx_go/rx_done pair
*/
`timescale 1ns/100ps

module uart_rx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rxd,
  input  logic                 rx_go,
  output logic                 rx_done,
  output uart_data_pkg::byte_t rx_data,
  output logic                 rx_frame_err
);

  import uart_cfg_pkg::*;
  import uart_data_pkg::*;

  rx_state_t state;
  // clocks left until the next sample point
  bit_cnt_t  cnt;
  // which data bit the next sample belongs to
  bit_idx_t  idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= rx_idle;
      cnt          <= '0;
      idx          <= '0;
      rx_data      <= '0;
      rx_frame_err <= 1'b0;
      rx_done      <= 1'b0;
    end else begin
      case (state)
        rx_idle: begin
          // a low line only counts as a start bit when a byte is wanted
          if (rx_go && !rxd) begin
            cnt   <= bit_cnt_t'(half_bit);
            state <= rx_start;
          end
        end

        rx_start: begin
          cnt <= cnt - bit_cnt_t'(1);
          if (cnt == '0) begin
            // now in the middle of the start bit and one full bit away from data bit 0
            cnt   <= bit_cnt_t'(clks_per_bit - 1);
            idx   <= '0;
            state <= uart_data_pkg::rx_data;
          end
        end

        uart_data_pkg::rx_data: begin
          cnt <= cnt - bit_cnt_t'(1);
          if (cnt == '0) begin
            // bits arrive LSB first, so the index places each one directly
            rx_data[idx] <= rxd;
            cnt          <= bit_cnt_t'(clks_per_bit - 1);
            idx          <= idx + bit_idx_t'(1);
            if (idx == 3'd7) begin
              state <= rx_stop;
            end
          end
        end

        rx_stop: begin
          cnt <= cnt - bit_cnt_t'(1);
          if (cnt == '0) begin
            // a low stop bit means the frame boundary was lost
            rx_frame_err <= !rxd;
            rx_done      <= 1'b1;
            state        <= rx_wait_release;
          end
        end

        rx_wait_release: begin
          // data stays valid until the controller drops rx_go
          if (!rx_go) begin
            rx_data      <= '0;
            rx_frame_err <= 1'b0;
            rx_done      <= 1'b0;
            state        <= rx_idle;
          end
        end

        default: begin
          state <= rx_idle;
        end
      endcase
    end
  end

  // the done level must already be gone once the FSM is back in idle,
  // otherwise the controller could see a stale byte on its next request
  a_no_done_in_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == rx_idle) |-> !rx_done
  );

endmodule

// File: design/uart_tx.sv
/*
  UART transmitter, 8N1, sends one framed byte per tx_go/tx_done handshake
*/
`timescale 1ns/100ps

module uart_tx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 tx_go,
  input  uart_data_pkg::byte_t tx_byte,
  output logic                 tx_done,
  output logic                 txd
);

  import uart_cfg_pkg::*;
  import uart_data_pkg::*;

  tx_state_t state;
  // clocks left in the bit that is on the line now
  bit_cnt_t  cnt;
  // counts the data bits already shifted out
  bit_idx_t  idx;
  // remaining data bits, the next one to send sits in bit 0
  byte_t     shift;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= tx_idle;
      cnt     <= '0;
      idx     <= '0;
      shift   <= '0;
      tx_done <= 1'b0;
      txd     <= 1'b1;
    end else begin
      case (state)
        tx_idle: begin
          if (tx_go) begin
            // start bit goes on the line right away
            shift <= tx_byte;
            cnt   <= bit_cnt_t'(clks_per_bit - 1);
            txd   <= 1'b0;
            state <= tx_start;
          end
        end

        tx_start: begin
          cnt <= cnt - bit_cnt_t'(1);
          if (cnt == '0) begin
            txd   <= shift[0];
            shift <= shift >> 1;
            cnt   <= bit_cnt_t'(clks_per_bit - 1);
            idx   <= '0;
            state <= tx_data;
          end
        end

        tx_data: begin
          cnt <= cnt - bit_cnt_t'(1);
          if (cnt == '0) begin
            cnt <= bit_cnt_t'(clks_per_bit - 1);
            if (idx == 3'd7) begin
              // last data bit done, line goes high for the stop bit
              txd   <= 1'b1;
              state <= tx_stop;
            end else begin
              txd   <= shift[0];
              shift <= shift >> 1;
              idx   <= idx + bit_idx_t'(1);
            end
          end
        end

        tx_stop: begin
          cnt <= cnt - bit_cnt_t'(1);
          if (cnt == '0) begin
            tx_done <= 1'b1;
            state   <= tx_wait_release;
          end
        end

        tx_wait_release: begin
          // line idles high while the controller finishes the handshake
          if (!tx_go) begin
            tx_done <= 1'b0;
            state   <= tx_idle;
          end
        end

        default: begin
          state <= tx_idle;
        end
      endcase
    end
  end

  // the line must rest at the stop level whenever no frame is in flight
  a_txd_high_at_rest: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == tx_idle || state == tx_wait_release) |-> txd
  );

endmodule

// File: design/uart_ctrl.sv
/*
  host channel controllers, one FSM per direction, bridging the host
  four-phase req/ack pairs to the receiver and transmitter handshakes
*/
`timescale 1ns/100ps

module uart_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 host_tx_req,
  input  uart_data_pkg::byte_t host_tx_data,
  output logic                 host_tx_ack,
  input  logic                 host_rx_req,
  output logic                 host_rx_ack,
  output uart_data_pkg::byte_t host_rx_data,
  output logic                 host_rx_frame_err,
  output logic                 rx_go,
  input  logic                 rx_done,
  input  uart_data_pkg::byte_t rx_data,
  input  logic                 rx_frame_err,
  output logic                 tx_go,
  input  logic                 tx_done,
  output uart_data_pkg::byte_t tx_byte
);

  import uart_data_pkg::*;

  ctrl_state_t tx_state;
  ctrl_state_t rx_state;

  // transmit channel, the byte is copied once and held for the whole frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_state    <= ctrl_idle;
      tx_go       <= 1'b0;
      tx_byte     <= '0;
      host_tx_ack <= 1'b0;
    end else begin
      case (tx_state)
        ctrl_idle: begin
          if (host_tx_req) begin
            tx_byte  <= host_tx_data;
            tx_state <= ctrl_busy;
          end
        end
        ctrl_busy: begin
          tx_go <= 1'b1;
          // host ack follows only after the transmitter has finished
          if (tx_go && tx_done) begin
            host_tx_ack <= 1'b1;
            tx_state    <= ctrl_ack;
          end
        end
        ctrl_ack: begin
          if (!host_tx_req) begin
            tx_go    <= 1'b0;
            tx_state <= ctrl_release;
          end
        end
        ctrl_release: begin
          // wait for the transmitter to close its side before the host may go again
          if (!tx_done) begin
            host_tx_ack <= 1'b0;
            tx_state    <= ctrl_idle;
          end
        end
        default: tx_state <= ctrl_idle;
      endcase
    end
  end

  // receive channel, the receiver wipes its outputs once rx_go falls,
  // so the byte and flag are captured here on rx_done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_state          <= ctrl_idle;
      rx_go             <= 1'b0;
      host_rx_ack       <= 1'b0;
      host_rx_data      <= '0;
      host_rx_frame_err <= 1'b0;
    end else begin
      case (rx_state)
        ctrl_idle: begin
          if (host_rx_req) begin
            rx_go    <= 1'b1;
            rx_state <= ctrl_busy;
          end
        end
        ctrl_busy: begin
          if (rx_done) begin
            host_rx_data      <= rx_data;
            host_rx_frame_err <= rx_frame_err;
            host_rx_ack       <= 1'b1;
            rx_state          <= ctrl_ack;
          end
        end
        ctrl_ack: begin
          if (!host_rx_req) begin
            rx_go    <= 1'b0;
            rx_state <= ctrl_release;
          end
        end
        ctrl_release: begin
          if (!rx_done) begin
            host_rx_ack <= 1'b0;
            rx_state    <= ctrl_idle;
          end
        end
        default: rx_state <= ctrl_idle;
      endcase
    end
  end

  // a new transmit request must not overlap the tail of the last handshake
  a_tx_go_after_done_low: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(tx_go) |-> !tx_done
  );

  // the receive ack only ever answers a host request that was pending
  a_rx_ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    host_rx_ack |-> ($past(host_rx_req) || $past(host_rx_ack))
  );

endmodule

// File: design/uart_link.sv
/*
  UART link top, wires the host channel controller to the receiver
  and the transmitter
*/
`timescale 1ns/100ps

module uart_link (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 host_tx_req,
  input  uart_data_pkg::byte_t host_tx_data,
  output logic                 host_tx_ack,
  input  logic                 host_rx_req,
  output logic                 host_rx_ack,
  output uart_data_pkg::byte_t host_rx_data,
  output logic                 host_rx_frame_err,
  input  logic                 rxd,
  output logic                 txd
);

  import uart_data_pkg::*;

  // receiver side handshake and its payload
  logic  rx_go;
  logic  rx_done;
  byte_t rx_data;
  logic  rx_frame_err;

  // transmitter side handshake and the byte to send
  logic  tx_go;
  logic  tx_done;
  byte_t tx_byte;

  uart_ctrl uart_ctrl_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .host_tx_req       (host_tx_req),
    .host_tx_data      (host_tx_data),
    .host_tx_ack       (host_tx_ack),
    .host_rx_req       (host_rx_req),
    .host_rx_ack       (host_rx_ack),
    .host_rx_data      (host_rx_data),
    .host_rx_frame_err (host_rx_frame_err),
    .rx_go             (rx_go),
    .rx_done           (rx_done),
    .rx_data           (rx_data),
    .rx_frame_err      (rx_frame_err),
    .tx_go             (tx_go),
    .tx_done           (tx_done),
    .tx_byte           (tx_byte)
  );

  uart_rx uart_rx_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .rxd          (rxd),
    .rx_go        (rx_go),
    .rx_done      (rx_done),
    .rx_data      (rx_data),
    .rx_frame_err (rx_frame_err)
  );

  uart_tx uart_tx_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_go   (tx_go),
    .tx_byte (tx_byte),
    .tx_done (tx_done),
    .txd     (txd)
  );

endmodule

// File: verification/uart_link_checker.sv
/*
  testbench checker, decodes txd frames on its own and compares
  the host receive results and handshake order against the pattern file
*/
`timescale 1ns/100ps

module uart_link_checker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 host_tx_req,
  input  logic                 host_tx_ack,
  input  logic                 host_rx_req,
  input  logic                 host_rx_ack,
  input  uart_data_pkg::byte_t host_rx_data,
  input  logic                 host_rx_frame_err,
  input  logic                 txd,
  input  logic                 run_done,
  output int                   errors
);

  import uart_cfg_pkg::*;

  // longest gap between two loop frames, bad frames included
  localparam int frame_timeout = 4000;

  logic [15:0] pat [32];
  logic [7:0]  loop_bytes [32];
  int          n_pat;
  int          n_loop;
  int          tx_errs;
  int          frames;
  int          mon_errs = 0;
  int          rx_seen = 0;
  logic        req_seen = 1'b0;
  logic        tx_ack_q = 1'b0;
  logic        rx_ack_q = 1'b0;
  logic        done_q = 1'b0;

  assign errors = tx_errs + mon_errs;

  // read the patterns, then decode every loop frame from txd in order
  initial begin
    logic [7:0] got;
    int         wait_n;
    tx_errs = 0;
    frames  = 0;
    n_pat   = 0;
    n_loop  = 0;
    for (int i = 0; i < 32; i++) begin
      pat[i] = 16'hffff;
    end
    $readmemh("verification/uart_patterns.txt", pat);
    for (int i = 0; i < 32; i++) begin
      if (pat[i] !== 16'hffff) begin
        n_pat++;
        // only loop lines put a frame on txd
        if (pat[i][15:12] == 4'h0) begin
          loop_bytes[n_loop] = pat[i][11:4];
          n_loop++;
        end
      end
    end
    wait_n = 0;
    while (rst_n !== 1'b1 && wait_n < 100) begin
      @(posedge clk);
      wait_n++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was never released");
      tx_errs++;
    end
    for (int f = 0; f < n_loop; f++) begin
      wait_n = 0;
      @(posedge clk);
      while (txd !== 1'b0 && wait_n < frame_timeout) begin
        @(posedge clk);
        wait_n++;
      end
      if (txd !== 1'b0) begin
        $display("no start bit on txd for loop frame %0d", f);
        tx_errs++;
        break;
      end
      // the low level is seen one clock into the start bit, so three more reach its middle
      repeat (clks_per_bit / 2 - 1) @(posedge clk);
      if (txd !== 1'b0) begin
        $display("Mismatch txd start bit: expected %h, got %h", 1'b0, txd);
        tx_errs++;
      end
      got = '0;
      // LSB arrives first and ends up in bit 0 after eight shifts
      repeat (8) begin
        repeat (clks_per_bit) @(posedge clk);
        got = {txd, got[7:1]};
      end
      if (got !== loop_bytes[f]) begin
        $display("Mismatch txd data: expected %h, got %h", loop_bytes[f], got);
        tx_errs++;
      end
      repeat (clks_per_bit) @(posedge clk);
      if (txd !== 1'b1) begin
        $display("Mismatch txd stop bit: expected %h, got %h", 1'b1, txd);
        tx_errs++;
      end
      frames++;
    end
  end

  // host side monitor for reset levels, receive results and ack ordering
  always @(posedge clk) begin
    if (rst_n) begin
      if (!req_seen) begin
        if (txd !== 1'b1 || host_tx_ack !== 1'b0 || host_rx_ack !== 1'b0) begin
          $display("Mismatch reset state txd/host_tx_ack/host_rx_ack: expected %h, got %h",
                   3'b100, {txd, host_tx_ack, host_rx_ack});
          mon_errs++;
        end
      end
      if (host_tx_req || host_rx_req) begin
        req_seen = 1'b1;
      end
      if (host_rx_ack && !rx_ack_q) begin
        if (!host_rx_req) begin
          $display("host_rx_ack rose while host_rx_req was low");
          mon_errs++;
        end
        if (rx_seen < n_pat) begin
          if (host_rx_data !== pat[rx_seen][11:4]) begin
            $display("Mismatch host_rx_data: expected %h, got %h",
                     pat[rx_seen][11:4], host_rx_data);
            mon_errs++;
          end
          if (host_rx_frame_err !== pat[rx_seen][0]) begin
            $display("Mismatch host_rx_frame_err: expected %h, got %h",
                     pat[rx_seen][0], host_rx_frame_err);
            mon_errs++;
          end
        end else begin
          $display("host_rx_ack rose more often than there are patterns");
          mon_errs++;
        end
        rx_seen++;
      end
      if (!host_rx_ack && rx_ack_q && host_rx_req) begin
        $display("host_rx_ack fell while host_rx_req was still high");
        mon_errs++;
      end
      if (host_tx_ack && !tx_ack_q && !host_tx_req) begin
        $display("host_tx_ack rose while host_tx_req was low");
        mon_errs++;
      end
      if (!host_tx_ack && tx_ack_q && host_tx_req) begin
        $display("host_tx_ack fell while host_tx_req was still high");
        mon_errs++;
      end
      // every pattern must have been answered once the stimulus is over
      if (run_done && !done_q) begin
        if (rx_seen != n_pat) begin
          $display("only %0d of %0d receive handshakes completed", rx_seen, n_pat);
          mon_errs++;
        end
        if (frames != n_loop) begin
          $display("only %0d of %0d txd frames were decoded", frames, n_loop);
          mon_errs++;
        end
      end
      tx_ack_q = host_tx_ack;
      rx_ack_q = host_rx_ack;
      done_q   = run_done;
    end
  end

endmodule

// File: verification/uart_link_tb.sv
/*
  testbench top for the UART link with clock, reset and pattern driven host
  requests that loop txd back to rxd or force bad frames on rxd
*/
`timescale 1ns/100ps

module uart_link_tb;

  import uart_cfg_pkg::*;

  // one frame is 10 bits, so this leaves a wide margin
  localparam int ack_timeout = 50 * clks_per_bit;

  logic        clk;
  logic        rst_n;
  logic        host_tx_req;
  logic [7:0]  host_tx_data;
  logic        host_tx_ack;
  logic        host_rx_req;
  logic        host_rx_ack;
  logic [7:0]  host_rx_data;
  logic        host_rx_frame_err;
  logic        rxd;
  logic        txd;
  logic        loop_mode;
  logic        line_drv;
  logic        run_done;
  logic        timed_out;
  int          timeouts;
  int          chk_errors;
  logic [15:0] pat [32];

  // serial line either loops back or is driven directly
  assign rxd = loop_mode ? txd : line_drv;

  uart_link uart_link_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .host_tx_req       (host_tx_req),
    .host_tx_data      (host_tx_data),
    .host_tx_ack       (host_tx_ack),
    .host_rx_req       (host_rx_req),
    .host_rx_ack       (host_rx_ack),
    .host_rx_data      (host_rx_data),
    .host_rx_frame_err (host_rx_frame_err),
    .rxd               (rxd),
    .txd               (txd)
  );

  uart_link_checker checker_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .host_tx_req       (host_tx_req),
    .host_tx_ack       (host_tx_ack),
    .host_rx_req       (host_rx_req),
    .host_rx_ack       (host_rx_ack),
    .host_rx_data      (host_rx_data),
    .host_rx_frame_err (host_rx_frame_err),
    .txd               (txd),
    .run_done          (run_done),
    .errors            (chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic ack_of(input logic rx_side);
    return rx_side ? host_rx_ack : host_tx_ack;
  endfunction

  // polls one host ack at each rising edge until it reaches the level
  task wait_ack(input logic rx_side, input logic level, input string name);
    int n;
    if (!timed_out) begin
      n = 0;
      @(posedge clk);
      while (ack_of(rx_side) !== level && n < ack_timeout) begin
        @(posedge clk);
        n++;
      end
      if (ack_of(rx_side) !== level) begin
        $display("timeout after %0d cycles waiting for %s to reach %0d", n, name, level);
        timeouts++;
        timed_out = 1'b1;
      end
    end
  endtask

  // start bit, 8 data bits LSB first and a stop bit held low
  task send_bad_frame(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b0, b, 1'b0};
    repeat (10) begin
      line_drv <= frame[0];
      frame = frame >> 1;
      repeat (clks_per_bit) @(posedge clk);
    end
    line_drv <= 1'b1;
  endtask

  // receive request goes first so the receiver is armed before the start bit
  task run_loop_op(input logic [7:0] b);
    loop_mode   <= 1'b1;
    host_rx_req <= 1'b1;
    @(posedge clk);
    host_tx_data <= b;
    host_tx_req  <= 1'b1;
    wait_ack(1'b0, 1'b1, "host_tx_ack");
    host_tx_req <= 1'b0;
    wait_ack(1'b0, 1'b0, "host_tx_ack");
    wait_ack(1'b1, 1'b1, "host_rx_ack");
    host_rx_req <= 1'b0;
    wait_ack(1'b1, 1'b0, "host_rx_ack");
  endtask

  task run_bad_op(input logic [7:0] b);
    loop_mode   <= 1'b0;
    host_rx_req <= 1'b1;
    // rx_go needs two clocks to reach the receiver
    repeat (3) @(posedge clk);
    send_bad_frame(b);
    wait_ack(1'b1, 1'b1, "host_rx_ack");
    host_rx_req <= 1'b0;
    wait_ack(1'b1, 1'b0, "host_rx_ack");
  endtask

  initial begin
    rst_n        = 1'b0;
    host_tx_req  = 1'b0;
    host_tx_data = '0;
    host_rx_req  = 1'b0;
    // rxd rests high from the driven line until the first loop operation
    loop_mode    = 1'b0;
    line_drv     = 1'b1;
    run_done     = 1'b0;
    timed_out    = 1'b0;
    timeouts     = 0;
    for (int i = 0; i < 32; i++) begin
      pat[i] = 16'hffff;
    end
    $readmemh("verification/uart_patterns.txt", pat);
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // a few idle cycles so the reset levels get watched
    repeat (3) @(posedge clk);
    for (int i = 0; i < 32; i++) begin
      if (pat[i] === 16'hffff || timed_out) begin
        break;
      end
      if (pat[i][15:12] == 4'h0) begin
        run_loop_op(pat[i][11:4]);
      end else begin
        run_bad_op(pat[i][11:4]);
      end
    end
    run_done <= 1'b1;
    repeat (3) @(posedge clk);
    $display("checker errors %0d, timeouts %0d", chk_errors, timeouts);
    if (chk_errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: verification/uart_patterns.txt
// opcode digit (0 loop through txd, 1 frame driven on rxd with a low stop bit),
// two digits of data byte, then the expected framing-error flag digit
0a50
0000
0ff0
0550
1a51
0810
1001
0c30
0fe0
17f1
0010
0800
13c1
0690

// File: uart_link.f
design/uart_cfg_pkg.sv
design/uart_data_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_ctrl.sv
design/uart_link.sv
verification/uart_link_checker.sv
verification/uart_link_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module uart_link_tb -f uart_link.f

output=$(./obj_dir/Vuart_link_tb)
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
else
  exit 1
fi
